/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --assert -Wno-fatal -j 0
TOP = fpuMulTb
FILELIST = fpuMul.f
OBJ_DIR = obj_dir
SIM_ARGS = +verilator+error+limit+1000
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Finished with errors" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* fpuMul.f */
+incdir+include
verilog/fpuPkg.sv
verilog/fpuInterfaces.sv
verilog/fpuMulControl.sv
verilog/sigMultiplier.sv
verilog/expSignUnit.sv
verilog/fpuNormalizer.sv
verilog/fpuMulTop.sv
test/fpuMul_sva.sv
test/fpuMulTb.sv

/* include/fpu_config.svh */
`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// Binary16 field widths.
`define FP_EXPW 5
`define FP_FRACW 10

// Exponent bias of the format.
`define FP_BIAS 15

// Radix-4 steps for an 11-bit significand, two bits per step.
`define SIG_ITERATIONS 6

`endif

/* test/fpuMulTb.sv */
module fpuMulTb import fpuPkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int WaitLimit = 40;
  localparam int DriveDelay = 5;

  logic clock;
  logic reset;
  logic inValid;
  logic inReady;
  fpWord_t operandA;
  fpWord_t operandB;
  logic outValid;
  logic outReady;
  fpWord_t result;
  condCode_t condCodes;
  statusFlag_t statusFlags;

  int timeoutCount;
  fpWord_t stimA[$];
  fpWord_t stimB[$];

  fpuMulTop uut (
    .clock(clock),
    .reset(reset),
    .inValid(inValid),
    .inReady(inReady),
    .operandA(operandA),
    .operandB(operandB),
    .outValid(outValid),
    .outReady(outReady),
    .result(result),
    .condCodes(condCodes),
    .statusFlags(statusFlags)
  );

  bind fpuMulTop fpuMulSva sva (
    .clock(clock),
    .reset(reset),
    .inValid(inValid),
    .inReady(inReady),
    .operandA(operandA),
    .operandB(operandB),
    .outValid(outValid),
    .outReady(outReady),
    .result(result),
    .condCodes(condCodes),
    .statusFlags(statusFlags)
  );

  always #50 clock = ~clock;

  function automatic fpWord_t randomWord(input int expLow, input int expHigh);
    return {1'($urandom_range(0, 1)), 5'($urandom_range(expLow, expHigh)),
            10'($urandom_range(0, 1023))};
  endfunction

  function automatic fpWord_t subnormalWord();
    return {1'($urandom_range(0, 1)), 5'd0, 10'($urandom_range(1, 1023))};
  endfunction

  task automatic addPair(input fpWord_t a, input fpWord_t b);
    stimA.push_back(a);
    stimB.push_back(b);
  endtask

  task automatic buildStimulus();
    // Zeros, infinities, NaNs and the invalid products.
    addPair(16'h0000, 16'h3C00);
    addPair(16'h8000, 16'h4000);
    addPair(16'h7C00, 16'h4000);
    addPair(16'h7C00, 16'hFC00);
    addPair(16'h7C00, 16'h0000);
    addPair(16'h8000, 16'hFC00);
    addPair(16'h7E00, 16'h3C00);
    addPair(16'h3C00, 16'h7D01);
    addPair(16'h7E00, 16'h0000);
    addPair(16'hFC00, 16'h0001);
    addPair(16'h3C00, 16'h3C00);
    addPair(16'h4000, 16'hC200);
    repeat (40) addPair(randomWord(8, 22), randomWord(8, 22));
    // Large exponents overflow, small ones land in subnormal range.
    repeat (10) addPair(randomWord(24, 30), randomWord(24, 30));
    repeat (15) addPair(randomWord(1, 10), randomWord(1, 10));
    repeat (15) addPair(subnormalWord(), randomWord(1, 30));
    repeat (3) addPair(subnormalWord(), subnormalWord());
  endtask

  task automatic sendOperands(input fpWord_t a, input fpWord_t b);
    int waited;
    waited = 0;
    operandA = a;
    operandB = b;
    inValid = 1'b1;
    while (!inReady && waited < WaitLimit) begin
      @(posedge clock);
      #DriveDelay;
      waited++;
    end
    if (!inReady) begin
      $display("Timeout: input handshake never raised inReady at %0t", $time);
      timeoutCount++;
    end else begin
      @(posedge clock);
      #DriveDelay;
    end
    inValid = 1'b0;
  endtask

  task automatic receiveResult();
    int waited;
    int stall;
    waited = 0;
    while (!outValid && waited < WaitLimit) begin
      @(posedge clock);
      #DriveDelay;
      waited++;
    end
    if (!outValid) begin
      $display("Timeout: output handshake never raised outValid at %0t", $time);
      timeoutCount++;
    end else begin
      // Random back-pressure before the result is taken.
      stall = $urandom_range(0, 5);
      repeat (stall) begin
        @(posedge clock);
        #DriveDelay;
      end
      outReady = 1'b1;
      @(posedge clock);
      #DriveDelay;
      outReady = 1'b0;
    end
  endtask

  task automatic sendAll();
    foreach (stimA[i]) begin
      sendOperands(stimA[i], stimB[i]);
    end
  endtask

  task automatic receiveAll(input int count);
    repeat (count) receiveResult();
  endtask

  initial begin
    int failures;
    void'($urandom(72736));
    clock = 1'b0;
    reset = 1'b1;
    inValid = 1'b0;
    operandA = '0;
    operandB = '0;
    outReady = 1'b0;
    timeoutCount = 0;
    buildStimulus();
    repeat (2) @(posedge clock);
    #DriveDelay;
    reset = 1'b0;
    fork
      sendAll();
      receiveAll(stimA.size());
    join
    repeat (3) @(posedge clock);
    failures = uut.sva.failCount;
    $display("Assertion failures: %0d, handshake timeouts: %0d", failures, timeoutCount);
    if (failures == 0 && timeoutCount == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* test/fpuMul_sva.sv */
module fpuMulSva import fpuPkg::*; (
  input logic clock,
  input logic reset,
  input logic inValid,
  input logic inReady,
  input fpWord_t operandA,
  input fpWord_t operandB,
  input logic outValid,
  input logic outReady,
  input fpWord_t result,
  input condCode_t condCodes,
  input statusFlag_t statusFlags
);
  timeunit 1ns;
  timeprecision 100ps;

  int failCount = 0;
  fpWord_t expectWord;
  statusFlag_t expectFlags;
  // Clocks since the accept edge saturate at the result cycle.
  logic [3:0] age;

  // Returns flags and result word from exact integer arithmetic.
  function automatic logic [19:0] refMultiply(input fpWord_t a, input fpWord_t b);
    logic sign;
    logic zeroA;
    logic zeroB;
    logic infA;
    logic infB;
    logic nanA;
    logic nanB;
    logic [10:0] sigA;
    logic [10:0] sigB;
    logic [21:0] prod;
    logic [63:0] ext;
    logic [63:0] kept;
    logic guard;
    logic sticky;
    logic inexact;
    int scale;
    int lead;
    int topExp;
    int shift;
    int encoded;
    sign = a[15] ^ b[15];
    zeroA = (a[14:0] == 15'd0);
    zeroB = (b[14:0] == 15'd0);
    infA = (a[14:0] == 15'h7C00);
    infB = (b[14:0] == 15'h7C00);
    nanA = (a[14:10] == 5'h1F) && (a[9:0] != 10'd0);
    nanB = (b[14:10] == 5'h1F) && (b[9:0] != 10'd0);
    if (nanA || nanB) return {4'b0000, 16'h7E00};
    if ((infA || infB) && (zeroA || zeroB)) return {4'b1000, 16'h7E00};
    if (infA || infB) return {4'b0000, sign, 15'h7C00};
    if (zeroA || zeroB) return {4'b0000, sign, 15'h0000};
    sigA = {a[14:10] != 5'd0, a[9:0]};
    sigB = {b[14:10] != 5'd0, b[9:0]};
    prod = sigA * sigB;
    // A significand counts in units of 2^(e-25) and a subnormal uses e = 1.
    scale = ((a[14:10] == 5'd0) ? 1 : int'(a[14:10]))
          + ((b[14:10] == 5'd0) ? 1 : int'(b[14:10])) - 50;
    lead = 0;
    for (int i = 0; i < 22; i++) begin
      if (prod[i]) lead = i;
    end
    topExp = lead + scale;
    if (topExp < -14) topExp = -14;
    // Keep 11 bits above the quantum 2^(topExp-10) in a field with 40 bits of headroom.
    shift = topExp - 10 - scale + 40;
    ext = 64'(prod) << 40;
    kept = ext >> shift;
    guard = ext[shift - 1];
    sticky = (ext & ((64'd1 << (shift - 1)) - 64'd1)) != 64'd0;
    inexact = guard || sticky;
    encoded = ((topExp + 14) << 10) + int'(kept[11:0]) + int'(guard && (sticky || kept[0]));
    if (encoded >= 31 * 1024) return {4'b0101, sign, 15'h7C00};
    return {1'b0, 1'b0, inexact && (encoded < 1024), inexact, sign, 15'(encoded)};
  endfunction

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      age <= '0;
    end else if (inValid && inReady) begin
      age <= 4'd1;
      {expectFlags, expectWord} <= refMultiply(operandA, operandB);
    end else if (outValid && outReady) begin
      age <= '0;
    end else if (age != 4'd0 && age < 4'd8) begin
      age <= age + 4'd1;
    end
  end

  resetState: assert property (@(posedge clock) reset |-> inReady && !outValid)
    else begin
      failCount++;
      $error("** Error at %0t: handshake outputs wrong in reset", $time);
    end

  earlyResult: assert property (@(posedge clock) disable iff (reset) age < 4'd8 |-> !outValid)
    else begin
      failCount++;
      $error("** Error at %0t: outValid before 8 clocks", $time);
    end

  lateResult: assert property (@(posedge clock) disable iff (reset) age == 4'd8 |-> outValid)
    else begin
      failCount++;
      $error("** Error at %0t: outValid missing at 8 clocks", $time);
    end

  busyRefuse: assert property (@(posedge clock) disable iff (reset) age != 4'd0 |-> !inReady)
    else begin
      failCount++;
      $error("** Error at %0t: inReady high while busy", $time);
    end

  readyReturn: assert property (@(posedge clock) disable iff (reset)
      outValid && outReady |=> inReady)
    else begin
      failCount++;
      $error("** Error at %0t: inReady low after output transfer", $time);
    end

  holdStable: assert property (@(posedge clock) disable iff (reset)
      outValid && !outReady |=> outValid && $stable(result) && $stable(condCodes)
      && $stable(statusFlags))
    else begin
      failCount++;
      $error("** Error at %0t: output changed while stalled", $time);
    end

  resultMatch: assert property (@(posedge clock) disable iff (reset)
      outValid |-> result == expectWord)
    else begin
      failCount++;
      $error("** Error at %0t: result %h, expected %h", $time, result, expectWord);
    end

  flagMatch: assert property (@(posedge clock) disable iff (reset)
      outValid |-> statusFlags == expectFlags)
    else begin
      failCount++;
      $error("** Error at %0t: flags %b, expected %b", $time, statusFlags, expectFlags);
    end

  codeMatch: assert property (@(posedge clock) disable iff (reset)
      outValid |-> condCodes == {expectWord[14:0] == 15'd0, expectWord[15]})
    else begin
      failCount++;
      $error("** Error at %0t: condition codes %b, expected %b", $time, condCodes,
             {expectWord[14:0] == 15'd0, expectWord[15]});
    end

endmodule

/* verilog/expSignUnit.sv */
`include "fpu_config.svh"

module expSignUnit import fpuPkg::*; (
  input logic clock,
  input logic reset,
  input logic captureOperands,
  input fpWord_t operandA,
  input fpWord_t operandB,
  sigMulIf.source mul,
  normIf.source norm
);

  localparam int SignBit = `FP_EXPW + `FP_FRACW;

  fpWord_t heldA;
  fpWord_t heldB;
  fpExp_t expA;
  fpExp_t expB;
  logic [`FP_FRACW-1:0] fracA;
  logic [`FP_FRACW-1:0] fracB;
  logic zeroA;
  logic zeroB;
  logic infA;
  logic infB;
  logic nanA;
  logic nanB;
  wideExp_t wideExp;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      heldA <= '0;
      heldB <= '0;
    end else if (captureOperands) begin
      heldA <= operandA;
      heldB <= operandB;
    end
  end

  assign expA = heldA[SignBit-1 -: `FP_EXPW];
  assign expB = heldB[SignBit-1 -: `FP_EXPW];
  assign fracA = heldA[`FP_FRACW-1:0];
  assign fracB = heldB[`FP_FRACW-1:0];

  // Hidden bit only for normal numbers.
  assign mul.sigA = {expA != '0, fracA};
  assign mul.sigB = {expB != '0, fracB};

  assign norm.sign = heldA[SignBit] ^ heldB[SignBit];

  // Subnormals scale like exponent 1.
  assign wideExp = ((expA == '0) ? wideExp_t'(1) : wideExp_t'(expA))
                 + ((expB == '0) ? wideExp_t'(1) : wideExp_t'(expB))
                 - wideExp_t'(`FP_BIAS);
  assign norm.wideExp = wideExp;
  assign norm.subShift = (wideExp < 1) ? fpExp_t'(1 - wideExp) : '0;

  assign zeroA = (expA == '0) && (fracA == '0);
  assign zeroB = (expB == '0) && (fracB == '0);
  assign infA = (expA == '1) && (fracA == '0);
  assign infB = (expB == '1) && (fracB == '0);
  assign nanA = (expA == '1) && (fracA != '0);
  assign nanB = (expB == '1) && (fracB != '0);

  // Invalid is raised only for infinity times zero.
  always_comb begin
    norm.invalid = 1'b0;
    if (nanA || nanB) begin
      norm.special = specialNan;
    end else if ((infA || infB) && (zeroA || zeroB)) begin
      norm.special = specialNan;
      norm.invalid = 1'b1;
    end else if (infA || infB) begin
      norm.special = specialInf;
    end else if (zeroA || zeroB) begin
      norm.special = specialZero;
    end else begin
      norm.special = specialNone;
    end
  end

endmodule

/* verilog/fpuInterfaces.sv */
// Significand operands, start and the finished product.
interface sigMulIf import fpuPkg::*; ();
  logic start;
  sig_t sigA;
  sig_t sigB;
  product_t product;
  logic done;

  modport control (output start, input done);
  modport source (output sigA, sigB);
  modport multiplier (input start, sigA, sigB, output product, done);
  modport sink (input product);
endinterface

// Exponent, sign and special-case information for the normalizer.
interface normIf import fpuPkg::*; ();
  logic sign;
  wideExp_t wideExp;
  fpExp_t subShift;
  special_t special;
  logic invalid;

  modport source (output sign, wideExp, subShift, special, invalid);
  modport sink (input sign, wideExp, subShift, special, invalid);
endinterface

/* verilog/fpuMulControl.sv */
module fpuMulControl import fpuPkg::*; (
  input logic clock,
  input logic reset,
  input logic inValid,
  output logic inReady,
  output logic outValid,
  input logic outReady,
  sigMulIf.control mul,
  output logic captureOperands,
  output logic normalizeStep
);

  controlState_t state;
  controlState_t nextState;
  logic startPulse;

  // Operands are only taken while nothing is in flight.
  assign inReady = (state == stateIdle);
  assign captureOperands = inValid && inReady;
  assign normalizeStep = (state == stateNormalize);
  assign outValid = (state == stateHold);

  // Multiplier kicks off the cycle after the accept edge.
  assign mul.start = startPulse;

  always_comb begin
    nextState = state;
    case (state)
      stateIdle: begin
        if (captureOperands) begin
          nextState = stateMultiply;
        end
      end
      stateMultiply: begin
        if (mul.done) begin
          nextState = stateNormalize;
        end
      end
      stateNormalize: begin
        nextState = stateHold;
      end
      default: begin
        // Result waits here until the consumer takes it.
        if (outReady) begin
          nextState = stateIdle;
        end
      end
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= stateIdle;
      startPulse <= 1'b0;
    end else begin
      state <= nextState;
      startPulse <= captureOperands;
    end
  end

endmodule

/* verilog/fpuMulTop.sv */
module fpuMulTop import fpuPkg::*; (
  input logic clock,
  input logic reset,
  input logic inValid,
  output logic inReady,
  input fpWord_t operandA,
  input fpWord_t operandB,
  output logic outValid,
  input logic outReady,
  output fpWord_t result,
  output condCode_t condCodes,
  output statusFlag_t statusFlags
);

  logic captureOperands;
  logic normalizeStep;

  sigMulIf mulBus ();
  normIf normBus ();

  fpuMulControl controlUnit (
    .clock(clock),
    .reset(reset),
    .inValid(inValid),
    .inReady(inReady),
    .outValid(outValid),
    .outReady(outReady),
    .mul(mulBus.control),
    .captureOperands(captureOperands),
    .normalizeStep(normalizeStep)
  );

  sigMultiplier multiplierUnit (
    .clock(clock),
    .reset(reset),
    .mul(mulBus.multiplier)
  );

  expSignUnit expSign (
    .clock(clock),
    .reset(reset),
    .captureOperands(captureOperands),
    .operandA(operandA),
    .operandB(operandB),
    .mul(mulBus.source),
    .norm(normBus.source)
  );

  fpuNormalizer normalizer (
    .clock(clock),
    .reset(reset),
    .normalizeStep(normalizeStep),
    .mul(mulBus.sink),
    .norm(normBus.sink),
    .result(result),
    .condCodes(condCodes),
    .statusFlags(statusFlags)
  );

endmodule

/* verilog/fpuNormalizer.sv */
`include "fpu_config.svh"

module fpuNormalizer import fpuPkg::*; (
  input logic clock,
  input logic reset,
  input logic normalizeStep,
  sigMulIf.sink mul,
  normIf.sink norm,
  output fpWord_t result,
  output condCode_t condCodes,
  output statusFlag_t statusFlags
);

  localparam int ProdW = 2 * `FP_FRACW + 2;
  localparam int ProdHidden = ProdW - 2;
  // Enough low padding that the deepest subnormal shift loses nothing.
  localparam int Pad = 16;
  localparam int ExtW = ProdW + Pad;
  localparam int HiddenBit = ProdHidden + Pad;
  localparam int PackW = `FP_EXPW + `FP_FRACW;
  localparam fpExp_t ExpMax = '1;
  localparam fpWord_t QuietNan = {1'b0, ExpMax, 1'b1, {(`FP_FRACW-1){1'b0}}};

  logic [$clog2(ProdW)-1:0] leadPos;
  wideExp_t leadZeros;
  wideExp_t shiftLeft;
  wideExp_t normExp;
  logic [ExtW-1:0] extended;
  logic [ExtW-1:0] aligned;
  logic [`FP_FRACW-1:0] mantissa;
  logic guardBit;
  logic stickyBit;
  logic roundUp;
  fpExp_t expField;
  logic [PackW-1:0] rounded;
  logic overflow;
  logic inexact;
  logic underflow;
  fpWord_t finalWord;
  statusFlag_t finalFlags;

  always_comb begin
    leadPos = '0;
    for (int i = 0; i < ProdW; i++) begin
      if (mul.product[i]) begin
        leadPos = ($clog2(ProdW))'(i);
      end
    end
  end

  assign leadZeros = wideExp_t'(ProdHidden) - wideExp_t'(leadPos);
  assign extended = {mul.product, {Pad{1'b0}}};

  // Put the leading one on the hidden bit, but never below exponent 1.
  always_comb begin
    shiftLeft = '0;
    if (norm.subShift != '0) begin
      aligned = extended >> norm.subShift;
      normExp = wideExp_t'(1);
    end else if (mul.product[ProdW-1]) begin
      aligned = extended >> 1;
      normExp = norm.wideExp + wideExp_t'(1);
    end else begin
      shiftLeft = (leadZeros < norm.wideExp - 1) ? leadZeros : norm.wideExp - wideExp_t'(1);
      aligned = extended << shiftLeft;
      normExp = norm.wideExp - shiftLeft;
    end
  end

  assign mantissa = aligned[HiddenBit-1 -: `FP_FRACW];
  assign guardBit = aligned[HiddenBit-1-`FP_FRACW];
  assign stickyBit = |aligned[HiddenBit-2-`FP_FRACW:0];
  assign roundUp = guardBit && (stickyBit || mantissa[0]);

  // No hidden bit left means a subnormal, exponent field zero.
  assign expField = aligned[HiddenBit] ? fpExp_t'(normExp) : '0;

  // A mantissa carry moves into the exponent field.
  assign rounded = {expField, mantissa} + PackW'(roundUp);
  assign overflow = (normExp >= wideExp_t'(ExpMax)) || (rounded[PackW-1 -: `FP_EXPW] == ExpMax);
  assign inexact = guardBit || stickyBit || overflow;
  assign underflow = inexact && !overflow && (rounded[PackW-1 -: `FP_EXPW] == '0);

  always_comb begin
    finalFlags = '0;
    finalFlags[3] = norm.invalid;
    case (norm.special)
      specialZero: finalWord = {norm.sign, {PackW{1'b0}}};
      specialInf: finalWord = {norm.sign, ExpMax, {`FP_FRACW{1'b0}}};
      specialNan: finalWord = QuietNan;
      default: begin
        if (overflow) begin
          finalWord = {norm.sign, ExpMax, {`FP_FRACW{1'b0}}};
        end else begin
          finalWord = {norm.sign, rounded};
        end
        finalFlags[2] = overflow;
        finalFlags[1] = underflow;
        finalFlags[0] = inexact;
      end
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      result <= '0;
      condCodes <= '0;
      statusFlags <= '0;
    end else if (normalizeStep) begin
      result <= finalWord;
      condCodes <= {finalWord[PackW-1:0] == '0, finalWord[PackW]};
      statusFlags <= finalFlags;
    end
  end

endmodule

/* verilog/fpuPkg.sv */
`include "fpu_config.svh"

package fpuPkg;

  // Format word with the sign in the MSB, then exponent, then fraction.
  typedef logic [`FP_EXPW + `FP_FRACW:0] fpWord_t;

  typedef logic [`FP_EXPW-1:0] fpExp_t;

  // Signed exponent with room for sums outside the encodable range.
  typedef logic signed [`FP_EXPW+1:0] wideExp_t;

  // Significand including the hidden bit.
  typedef logic [`FP_FRACW:0] sig_t;

  typedef logic [2*`FP_FRACW+1:0] product_t;

  // Bit 1 is zero, bit 0 is negative.
  typedef logic [1:0] condCode_t;

  // Bits from the top are invalid, overflow, underflow, inexact.
  typedef logic [3:0] statusFlag_t;

  typedef enum logic [1:0] {
    specialNone,
    specialZero,
    specialInf,
    specialNan
  } special_t;

  typedef enum logic [1:0] {
    stateIdle,
    stateMultiply,
    stateNormalize,
    stateHold
  } controlState_t;

endpackage

/* verilog/sigMultiplier.sv */
`include "fpu_config.svh"

module sigMultiplier import fpuPkg::*; (
  input logic clock,
  input logic reset,
  sigMulIf.multiplier mul
);

  localparam int CountWidth = $clog2(`SIG_ITERATIONS + 1);

  product_t multiplicand;
  sig_t multiplierBits;
  product_t accumulator;
  logic [CountWidth-1:0] stepsLeft;
  logic busy;

  product_t stepMultiplicand;
  sig_t stepMultiplier;
  product_t partial;
  product_t accumulatorNext;

  // The start cycle already performs the first step on the live operands.
  always_comb begin
    stepMultiplicand = mul.start ? product_t'(mul.sigA) : multiplicand;
    stepMultiplier = mul.start ? mul.sigB : multiplierBits;
    case (stepMultiplier[1:0])
      2'd0: partial = '0;
      2'd1: partial = stepMultiplicand;
      2'd2: partial = stepMultiplicand << 1;
      default: partial = stepMultiplicand + (stepMultiplicand << 1);
    endcase
    if (mul.start) begin
      accumulatorNext = partial;
    end else if (busy) begin
      accumulatorNext = accumulator + partial;
    end else begin
      accumulatorNext = accumulator;
    end
  end

  // Product is complete during the last step and holds afterwards.
  assign mul.product = accumulatorNext;
  assign mul.done = busy && (stepsLeft == CountWidth'(1));

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      busy <= 1'b0;
      stepsLeft <= '0;
    end else if (mul.start) begin
      busy <= 1'b1;
      stepsLeft <= CountWidth'(`SIG_ITERATIONS - 1);
    end else if (busy) begin
      busy <= (stepsLeft != CountWidth'(1));
      stepsLeft <= stepsLeft - CountWidth'(1);
    end
  end

  always_ff @(posedge clock) begin
    if (mul.start || busy) begin
      accumulator <= accumulatorNext;
      multiplicand <= stepMultiplicand << 2;
      multiplierBits <= stepMultiplier >> 2;
    end
  end

endmodule
